/* Bender.yml */
package:
  name: g2048

sources:
  - include_dirs:
      - design
    files:
      - design/g2048_pkg.sv
      - design/g2048_bus_regs.sv
      - design/board_orient.sv
      - design/line_merge.sv
      - design/board_restore.sv
      - design/g2048_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/g2048_clk_gen.sv
      - test/g2048_assert.sv
      - test/g2048_tb.sv

/* design/board_orient.sv */
`include "g2048_settings.svh"

module board_orient (
	input  logic                 clk,
	input  logic                 rst_n,
	input  g2048_pkg::move_req_t move_req,
	output g2048_pkg::lines_t    lines
);

	g2048_pkg::line_t [`G2048_N-1:0] line_sel;
	g2048_pkg::line_t [`G2048_N-1:0] line_q;
	g2048_pkg::dir_t                 dir_q;
	logic                            valid_q;

	// pick row or column per line, slide end lands on tile 0
	always_comb begin
		for (int k = 0; k < `G2048_N; k++) begin
			for (int i = 0; i < `G2048_N; i++) begin
				line_sel[k].tile[i] =
					move_req.board[g2048_pkg::board_index(move_req.dir, k, i)];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= move_req.valid;
	end

	// payload only loads on a move so dir stays put for the restore step
	always_ff @(posedge clk) begin
		if (move_req.valid) begin
			dir_q  <= move_req.dir;
			line_q <= line_sel;
		end
	end

	assign lines = '{valid: valid_q, dir: dir_q, line: line_q};

endmodule

/* design/board_restore.sv */
`include "g2048_settings.svh"

module board_restore (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  g2048_pkg::dir_t                     dir,
	input  g2048_pkg::merged_t [`G2048_N-1:0]   results,
	input  g2048_pkg::board_t                   old_board,
	output g2048_pkg::board_t                   new_board,
	output logic                                done,
	output logic                                win,
	output logic                                lose
);

	localparam int CELLS = `G2048_N * `G2048_N;

	g2048_pkg::dir_t   dir_q;
	g2048_pkg::board_t assembled;
	g2048_pkg::board_t placed;
	logic [3:0]        lfsr;
	logic [3:0]        lfsr_next;
	logic              any_changed;
	logic              has_goal;
	logic              full;
	logic              has_pair;

	// first empty cell at or after start, wraps 15 -> 0
	function automatic g2048_pkg::board_t place_tile(input g2048_pkg::board_t b,
	                                                 input logic [3:0] start);
		g2048_pkg::board_t r;
		logic [3:0]        idx;
		logic              found;
		r     = b;
		found = 1'b0;
		for (int off = 0; off < CELLS; off++) begin
			idx = start + 4'(off);
			if (!found && r[idx] == '0) begin
				r[idx] = g2048_pkg::tile_t'(1); // a 2
				found  = 1'b1;
			end
		end
		return r;
	endfunction

	// orient holds dir between moves so a plain copy lines up with the merge output
	always_ff @(posedge clk) begin
		dir_q <= dir;
	end

	always_comb begin
		assembled   = '0;
		any_changed = 1'b0;
		for (int k = 0; k < `G2048_N; k++) begin
			any_changed = any_changed | results[k].changed;
			for (int i = 0; i < `G2048_N; i++) begin
				assembled[g2048_pkg::board_index(dir_q, k, i)] = results[k].line.tile[i];
			end
		end
	end

	assign lfsr_next = {lfsr[2:0], lfsr[3] ^ lfsr[2]}; // taps 3 and 2
	assign placed    = any_changed ? place_tile(assembled, lfsr_next) : assembled;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr <= `G2048_LFSR_SEED;
			done <= 1'b0;
		end else begin
			done <= in_valid;
			if (in_valid && any_changed)
				lfsr <= lfsr_next; // no step on a dead move
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			new_board <= placed;
	end

	// status from the live board register
	always_comb begin
		has_goal = 1'b0;
		full     = 1'b1;
		has_pair = 1'b0;
		for (int r = 0; r < `G2048_N; r++) begin
			for (int c = 0; c < `G2048_N; c++) begin
				if (old_board[r*`G2048_N + c] == '0)
					full = 1'b0;
				if (old_board[r*`G2048_N + c] == g2048_pkg::tile_t'(`G2048_GOAL))
					has_goal = 1'b1;
				if (c < `G2048_N - 1 &&
				    old_board[r*`G2048_N + c] == old_board[r*`G2048_N + c + 1])
					has_pair = 1'b1; // horizontal
				if (r < `G2048_N - 1 &&
				    old_board[r*`G2048_N + c] == old_board[(r+1)*`G2048_N + c])
					has_pair = 1'b1; // vertical
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			win  <= 1'b0;
			lose <= 1'b0;
		end else begin
			win  <= has_goal;
			lose <= full && !has_pair;
		end
	end

endmodule

/* design/g2048_bus_regs.sv */
`include "g2048_settings.svh"

module g2048_bus_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [4:0]           adr,
	input  logic [31:0]          dat_w,
	output logic [31:0]          dat_r,
	output logic                 ack,
	output g2048_pkg::move_req_t move_req,
	input  g2048_pkg::board_t    new_board,
	input  logic                 done,
	input  logic                 win,
	input  logic                 lose
);

	g2048_pkg::board_t  board_q;
	g2048_pkg::dir_t    move_dir;
	g2048_pkg::status_t status;
	logic               busy;
	logic               move_valid;
	logic               accept;
	logic               tile_sel;
	logic               wr_tile;
	logic               wr_move;
	logic [31:0]        rd_data;

	// writes stall while a move is in flight, reads always go through
	assign accept   = cyc && stb && !ack && (!we || !busy);
	assign tile_sel = (adr[4] == 1'b0); // 0..15
	assign wr_tile  = accept && we && tile_sel;
	assign wr_move  = accept && we && (adr == `G2048_ADDR_MOVE);

	assign status = '{rsvd: '0, lose: lose, win: win, busy: busy};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack        <= 1'b0;
			busy       <= 1'b0;
			move_valid <= 1'b0;
		end else begin
			ack        <= accept; // one cycle after the strobe is taken
			move_valid <= wr_move;
			if (wr_move)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	// board register, done and tile writes never coincide since writes wait on busy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			board_q <= '0;
		end else if (done) begin
			board_q <= new_board;
		end else if (wr_tile) begin
			board_q[adr[3:0]] <= dat_w[`G2048_TILE_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_move)
			move_dir <= g2048_pkg::dir_t'(dat_w[1:0]);
	end

	// board field is the live register, it cannot change while busy
	assign move_req = '{valid: move_valid, dir: move_dir, board: board_q};

	always_comb begin
		rd_data = '0;
		if (tile_sel)
			rd_data[`G2048_TILE_W-1:0] = board_q[adr[3:0]];
		else if (adr == `G2048_ADDR_STATUS)
			rd_data = status;
	end

	always_ff @(posedge clk) begin
		if (accept && !we)
			dat_r <= rd_data; // valid with ack
	end

endmodule

/* design/g2048_pkg.sv */
`include "g2048_settings.svh"

package g2048_pkg;

	typedef logic [`G2048_TILE_W-1:0] tile_t; // exponent, 0 = empty

	// tile[0] is the end the tiles slide toward
	typedef struct packed {
		tile_t [`G2048_N-1:0] tile;
	} line_t;

	typedef tile_t [`G2048_N*`G2048_N-1:0] board_t; // row*4 + col

	typedef enum logic [1:0] {
		DIR_LEFT  = 2'd0,
		DIR_RIGHT = 2'd1,
		DIR_UP    = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	typedef struct packed {
		logic   valid;
		dir_t   dir;
		board_t board;
	} move_req_t;

	typedef struct packed {
		logic                  valid;
		dir_t                  dir;
		line_t [`G2048_N-1:0]  line;
	} lines_t;

	typedef struct packed {
		line_t line;
		logic  changed;
	} merged_t;

	typedef struct packed {
		logic [28:0] rsvd;
		logic        lose;
		logic        win;
		logic        busy; // bit 0
	} status_t;

	// board cell that holds tile i of line k for a given slide direction
	function automatic logic [3:0] board_index(input dir_t dir, input int k, input int i);
		int r;
		int c;
		case (dir)
			DIR_LEFT: begin
				r = k;
				c = i;
			end
			DIR_RIGHT: begin
				r = k;
				c = `G2048_N - 1 - i;
			end
			DIR_UP: begin
				r = i;
				c = k;
			end
			default: begin // down
				r = `G2048_N - 1 - i;
				c = k;
			end
		endcase
		return 4'(r * `G2048_N + c);
	endfunction

endpackage

/* design/g2048_settings.svh */
`ifndef G2048_SETTINGS_SVH
`define G2048_SETTINGS_SVH

// board geometry
`define G2048_N         4
`define G2048_TILE_W    4

// exponent 11 is the 2048 tile
`define G2048_GOAL      11

// start value of the placement lfsr, must be nonzero
`define G2048_LFSR_SEED 4'b1001

// register map above the 16 tile slots
`define G2048_ADDR_MOVE   5'd16
`define G2048_ADDR_STATUS 5'd17

`endif

/* design/g2048_top.sv */
`include "g2048_settings.svh"

module g2048_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [4:0]  adr,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack
);

	g2048_pkg::move_req_t              move_req;
	g2048_pkg::lines_t                 lines;
	g2048_pkg::merged_t [`G2048_N-1:0] merged;
	logic [`G2048_N-1:0]               merge_valid;
	g2048_pkg::board_t                 new_board;
	logic                              done;
	logic                              win;
	logic                              lose;

	g2048_bus_regs u_bus (
		.clk       (clk),
		.rst_n     (rst_n),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.ack       (ack),
		.move_req  (move_req),
		.new_board (new_board),
		.done      (done),
		.win       (win),
		.lose      (lose)
	);

	board_orient u_orient (
		.clk      (clk),
		.rst_n    (rst_n),
		.move_req (move_req),
		.lines    (lines)
	);

	// one merge unit per line
	for (genvar g = 0; g < `G2048_N; g++) begin : g_merge
		line_merge u_merge (
			.clk       (clk),
			.rst_n     (rst_n),
			.in_valid  (lines.valid),
			.line_in   (lines.line[g]),
			.out_valid (merge_valid[g]),
			.result    (merged[g])
		);
	end

	board_restore u_restore (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (&merge_valid), // all four move together
		.dir       (lines.dir),
		.results   (merged),
		.old_board (move_req.board),
		.new_board (new_board),
		.done      (done),
		.win       (win),
		.lose      (lose)
	);

endmodule

/* design/line_merge.sv */
`include "g2048_settings.svh"

module line_merge (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  g2048_pkg::line_t   line_in,
	output logic               out_valid,
	output g2048_pkg::merged_t result
);

	g2048_pkg::line_t packed_in;
	g2048_pkg::line_t merged;
	g2048_pkg::line_t line_out;

	// squeeze out empty cells, order kept
	function automatic g2048_pkg::line_t pack_line(input g2048_pkg::line_t l);
		g2048_pkg::line_t p;
		int               k;
		p = '0;
		k = 0;
		for (int i = 0; i < `G2048_N; i++) begin
			if (l.tile[i] != '0) begin
				p.tile[k] = l.tile[i];
				k++;
			end
		end
		return p;
	endfunction

	// one pass from index 0, a merged pair leaves a hole behind it
	function automatic g2048_pkg::line_t merge_pairs(input g2048_pkg::line_t l);
		g2048_pkg::line_t m;
		m = l;
		for (int i = 0; i < `G2048_N - 1; i++) begin
			if (m.tile[i] != '0 && m.tile[i] == m.tile[i+1]) begin
				m.tile[i]   = m.tile[i] + 1'b1;
				m.tile[i+1] = '0; // hole stops a second merge
			end
		end
		return m;
	endfunction

	always_comb begin
		packed_in = pack_line(line_in);
		merged    = merge_pairs(packed_in);
		line_out  = pack_line(merged);
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			result.line    <= line_out;
			result.changed <= (line_out != line_in);
		end
	end

endmodule

/* g2048.f */
+incdir+design
design/g2048_pkg.sv
design/g2048_bus_regs.sv
design/board_orient.sv
design/line_merge.sv
design/board_restore.sv
design/g2048_top.sv
test/g2048_clk_gen.sv
test/g2048_assert.sv
test/g2048_tb.sv

/* test/g2048_assert.sv */
`include "g2048_settings.svh"

module g2048_assert (
	input logic       clk,
	input logic       rst_n,
	input logic       cyc,
	input logic       stb,
	input logic       we,
	input logic [4:0] adr,
	input logic       ack,
	input logic       busy
);

	int failures = 0;

	// ack only answers a live strobe
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |-> cyc && stb)
		else begin
			failures++;
			$error("ack high without cyc and stb");
		end

	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else begin
			failures++;
			$error("ack held for more than one cycle");
		end

	// orient, merge, restore, then the board register
	a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
		(ack && we && adr == `G2048_ADDR_MOVE) |-> busy ##1 busy ##1 busy ##1 busy ##1 !busy)
		else begin
			failures++;
			$error("busy not high for exactly 4 cycles after a move ack");
		end

endmodule

bind g2048_top g2048_assert assert_i (
	.clk   (clk),
	.rst_n (rst_n),
	.cyc   (cyc),
	.stb   (stb),
	.we    (we),
	.adr   (adr),
	.ack   (ack),
	.busy  (u_bus.busy)
);

/* test/g2048_clk_gen.sv */
module g2048_clk_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

/* test/g2048_patterns.txt */
# L r0 r1 r2 r3: load 16 tiles, each row four hex exponents, column 0 first
# M d: move, d is 0 left, 1 right, 2 up, 3 down
# B d a v: move d, then at once write hex value v to tile a
# E r0 r1 r2 r3 s: expected board and status word, bit 0 busy, bit 1 win, bit 2 lose
# reset state
E 0000 0000 0000 0000 0
# load and read back
L 0123 4560 789a 0cde
E 0123 4560 789a 0cde 0
# left with a run of four and a triple, new tile at 3
L 1111 2220 0101 3004
M 0
E 2201 3200 2000 3400 0
# right on that result, start 6 is taken so the tile goes to 8
M 1
E 0031 0032 1002 0034 0
# up, 5 4 4 gives 5 5 and stops there
L 1035 1230 1034 1204
M 2
E 2345 2035 0000 0100 0
# down, placement wraps from 15 to 0
L 2106 2040 2046 2147
M 3
E 1000 0000 3047 3257 0
# left changes nothing and the lfsr holds
L 1000 2000 3400 0000
M 0
E 1000 2000 3400 0000 0
# next placement uses start 5
M 1
E 0001 0102 0034 0000 0
# up with a tile write held behind it
B 2 01 9
E 0931 0002 0004 1000 0
# win through a merge
L aa00 0000 0000 0000
M 0
E b000 0001 0000 0000 2
# full board without equal neighbours
L 1212 2121 1212 2121
E 1212 2121 1212 2121 4
# full board with one equal pair
L 1212 2121 1212 2133
E 1212 2121 1212 2133 0

/* test/g2048_tb.sv */
`include "g2048_settings.svh"

module g2048_tb;

	localparam int DRIVE_DLY = 2;  // after the rising edge
	localparam int TIMEOUT   = 50; // cycles per wait

	logic        clk;
	logic        rst_n;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [4:0]  adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic        ack;

	int errors   = 0;
	int timeouts = 0;
	int cycle    = 0;

	g2048_clk_gen clk_gen_i (.clk(clk));

	g2048_top dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	// pattern rows are four hex digits, column 0 first
	function automatic g2048_pkg::board_t rows_to_board(input logic [63:0] rows);
		g2048_pkg::board_t b;
		for (int r = 0; r < `G2048_N; r++) begin
			for (int c = 0; c < `G2048_N; c++) begin
				b[r*`G2048_N + c] = rows[63 - 16*r - 4*c -: 4];
			end
		end
		return b;
	endfunction

	task automatic wait_ack(output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DLY;
			n++;
			seen = (ack === 1'b1);
		end
		if (!seen) begin
			$display("timeout: no ack for the bus cycle to address %0d", adr);
			timeouts++;
		end
	endtask

	// strobe stays up through the ack cycle, dropped after the next edge
	task automatic bus_write(input logic [4:0] a, input logic [31:0] d, output int ack_at);
		bit seen;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = a;
		dat_w = d;
		wait_ack(seen);
		ack_at = cycle;
		if (seen) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic bus_read(input logic [4:0] a, output logic [31:0] d, output bit ok);
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = a;
		wait_ack(ok);
		d = dat_r; // registered with ack
		if (ok) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic load_board(input g2048_pkg::board_t b);
		int at;
		for (int i = 0; i < `G2048_N * `G2048_N; i++)
			bus_write(5'(i), 32'(b[i]), at);
	endtask

	// poll status until the move has left the pipeline
	task automatic wait_idle();
		g2048_pkg::status_t st;
		logic [31:0]        d;
		bit                 ok;
		int                 start;
		start = cycle;
		ok    = 1'b1;
		st    = '0;
		st.busy = 1'b1;
		while (ok && st.busy !== 1'b0 && cycle - start < TIMEOUT) begin
			bus_read(`G2048_ADDR_STATUS, d, ok);
			st = g2048_pkg::status_t'(d);
		end
		if (ok && st.busy !== 1'b0) begin
			$display("timeout: busy did not clear after a move");
			timeouts++;
		end
	endtask

	task automatic run_move(input logic [1:0] dir);
		int at;
		bus_write(`G2048_ADDR_MOVE, 32'(dir), at);
		wait_idle();
	endtask

	task automatic move_then_write(input logic [1:0] dir, input logic [4:0] a,
	                               input logic [31:0] d);
		int move_at;
		int write_at;
		bus_write(`G2048_ADDR_MOVE, 32'(dir), move_at);
		bus_write(a, d, write_at); // held while busy
		// result lands 4 cycles after the move ack, the held write goes one cycle later
		if (write_at - move_at != 5) begin
			$display("[ERROR] ack delay of held write: expected 0x%h, got 0x%h",
			         5, write_at - move_at);
			errors++;
		end
		wait_idle();
	endtask

	task automatic check_board(input g2048_pkg::board_t exp, input g2048_pkg::status_t exp_st);
		logic [31:0] d;
		bit          ok;
		for (int i = 0; i < `G2048_N * `G2048_N; i++) begin
			bus_read(5'(i), d, ok);
			if (ok && d !== 32'(exp[i])) begin
				$display("[ERROR] dat_r tile %0d: expected 0x%h, got 0x%h", i, 32'(exp[i]), d);
				errors++;
			end
		end
		bus_read(`G2048_ADDR_STATUS, d, ok);
		if (ok && d !== exp_st) begin
			$display("[ERROR] dat_r status: expected 0x%h, got 0x%h", exp_st, d);
			errors++;
		end
	endtask

	initial begin
		int            fd;
		int            code;
		bit            reading;
		logic [63:0]   kind;
		logic [2047:0] skip;
		logic [15:0]   r0;
		logic [15:0]   r1;
		logic [15:0]   r2;
		logic [15:0]   r3;
		logic [31:0]   v0;
		logic [31:0]   v1;
		logic [31:0]   v2;
		rst_n = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		fd = $fopen("test/g2048_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file test/g2048_patterns.txt");
			errors++;
		end
		reading = (fd != 0);
		while (reading && timeouts == 0) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				reading = 1'b0; // end of file
			end else if (kind == "#") begin
				code = $fgets(skip, fd);
			end else if (kind == "L") begin
				code = $fscanf(fd, "%h %h %h %h", r0, r1, r2, r3);
				load_board(rows_to_board({r0, r1, r2, r3}));
			end else if (kind == "M") begin
				code = $fscanf(fd, "%h", v0);
				run_move(v0[1:0]);
			end else if (kind == "B") begin
				code = $fscanf(fd, "%h %h %h", v0, v1, v2);
				move_then_write(v0[1:0], v1[4:0], v2);
			end else if (kind == "E") begin
				code = $fscanf(fd, "%h %h %h %h %h", r0, r1, r2, r3, v0);
				check_board(rows_to_board({r0, r1, r2, r3}), g2048_pkg::status_t'(v0));
			end else begin
				$display("unknown record kind in the pattern file: %0s", kind);
				errors++;
				reading = 1'b0;
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("errors: %0d checks, %0d timeouts, %0d assertions",
		         errors, timeouts, dut_i.assert_i.failures);
		if (errors == 0 && timeouts == 0 && dut_i.assert_i.failures == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
